// File: rtl/rv_decode_pkg.sv
package rv_decode_pkg;

    // RV32I major opcodes
    localparam logic [6:0] LUI_OP    = 7'b0110111;
    localparam logic [6:0] AUIPC_OP  = 7'b0010111;
    localparam logic [6:0] JAL_OP    = 7'b1101111;
    localparam logic [6:0] JALR_OP   = 7'b1100111;
    localparam logic [6:0] BRANCH_OP = 7'b1100011;
    localparam logic [6:0] LOAD_OP   = 7'b0000011;
    localparam logic [6:0] STORE_OP  = 7'b0100011;
    localparam logic [6:0] I_TYPE_OP = 7'b0010011;
    localparam logic [6:0] R_TYPE_OP = 7'b0110011;
    localparam logic [6:0] SYSTEM_OP = 7'b1110011;

    // Queue entries, also the fetch credits at reset
    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int unsigned QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Execute-side credits at reset
    localparam int unsigned EX_CREDITS  = 2;
    localparam int unsigned EX_CREDIT_W = $clog2(EX_CREDITS + 1);

    typedef enum logic [2:0] {
        I_TYPE       = 3'b000,
        B_TYPE       = 3'b001,
        S_TYPE       = 3'b010,
        U_TYPE       = 3'b011,
        J_TYPE       = 3'b100,
        SHAMT_TYPE   = 3'b101,
        CSR_TYPE     = 3'b110,
        DEFAULT_TYPE = 3'b111
    } imm_type_e;

    // Standard RISC-V instruction formats, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, viewed in each format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        logic [31:0] pc;
        instr_u      ir;
    } fetch_pkt_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [11:0] csr_addr;
        logic [31:0] imm;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic        wr_reg_n;  // 0 means write
        logic        wr_csr_n;  // 0 means write
    } decoded_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

endpackage

// File: rtl/imm_extractor.sv
module imm_extractor import rv_decode_pkg::*; (
    input  instr_u      ir,
    input  imm_type_e   imm_type,
    output logic [31:0] imm
);

    always_comb begin
        unique case (imm_type)
            I_TYPE: begin
                imm = {{20{ir.i.imm_11_0[11]}}, ir.i.imm_11_0};
            end
            S_TYPE: begin
                imm = {{20{ir.s.imm_11_5[6]}}, ir.s.imm_11_5, ir.s.imm_4_0};
            end
            B_TYPE: begin
                // Branch offsets are halfword aligned
                imm = {{19{ir.b.imm_12}},
                       ir.b.imm_12,
                       ir.b.imm_11,
                       ir.b.imm_10_5,
                       ir.b.imm_4_1,
                       1'b0};
            end
            U_TYPE: begin
                imm = {ir.u.imm_31_12, 12'b0};
            end
            J_TYPE: begin
                imm = {{11{ir.j.imm_20}},
                       ir.j.imm_20,
                       ir.j.imm_19_12,
                       ir.j.imm_11,
                       ir.j.imm_10_1,
                       1'b0};
            end
            SHAMT_TYPE: begin
                // Shift amount sits in the rs2 slot
                imm = {27'b0, ir.r.rs2};
            end
            CSR_TYPE: begin
                // zimm sits in the rs1 slot, never sign extended
                imm = {27'b0, ir.i.rs1};
            end
            DEFAULT_TYPE: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: rtl/inst_queue.sv
module inst_queue import rv_decode_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  fetch_pkt_t in_pkt,
    input  logic       pop,
    output logic       head_valid,
    output fetch_pkt_t head_pkt,
    output logic       fetch_credit
);

    fetch_pkt_t mem [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;

    function automatic logic [QUEUE_PTR_W-1:0] next_ptr(input logic [QUEUE_PTR_W-1:0] ptr);
        if (ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Fetch credits bound the writes to free entries
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_pkt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            unique case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One credit back per freed entry, a cycle after the pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_credit <= 1'b0;
        end else begin
            fetch_credit <= pop;
        end
    end

    assign head_valid = (count != '0);
    assign head_pkt   = mem[rd_ptr];

endmodule

// File: rtl/reg_file.sv
module reg_file import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic        rd_en,
    input  wb_t         wb,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    // Zero for x0, bypass for a write on the same edge
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        if (wb.we && (wb.rd == addr)) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && (wb.rd != 5'd0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs1_data <= '0;
            rs2_data <= '0;
        end else if (rd_en) begin
            rs1_data <= read_port(rs1);
            rs2_data <= read_port(rs2);
        end
    end

endmodule

// File: rtl/id_stage.sv
module id_stage import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        head_valid,
    input  fetch_pkt_t  head_pkt,
    output logic        pop,
    input  logic        ex_credit,
    output imm_type_e   imm_type,
    input  logic [31:0] imm,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output logic        dec_valid,
    output decoded_t    dec_pkt
);

    logic [EX_CREDIT_W-1:0] ex_cnt;
    decoded_t               dec_d;
    decoded_t               dec_q;

    function automatic imm_type_e imm_type_from(input logic [6:0] opcode,
                                                input logic [2:0] funct3);
        unique case (opcode)
            LUI_OP, AUIPC_OP:         return U_TYPE;
            JAL_OP:                   return J_TYPE;
            JALR_OP, LOAD_OP:         return I_TYPE;
            BRANCH_OP:                return B_TYPE;
            STORE_OP:                 return S_TYPE;
            // SLLI, SRLI and SRAI carry a shift amount
            I_TYPE_OP: begin
                if ((funct3 == 3'b001) || (funct3 == 3'b101)) begin
                    return SHAMT_TYPE;
                end
                return I_TYPE;
            end
            SYSTEM_OP:                return CSR_TYPE;
            default:                  return DEFAULT_TYPE;
        endcase
    endfunction

    // CSR ops share the SYSTEM opcode with ecall/ebreak, which have funct3 = 0
    function automatic logic is_csr_op(input logic [6:0] opcode, input logic [2:0] funct3);
        return (opcode == SYSTEM_OP) && (funct3 != 3'b000);
    endfunction

    // Whitelist of writers, never x0
    function automatic logic wr_reg_n_ctrl(input logic [6:0] opcode,
                                           input logic [4:0] rd,
                                           input logic [2:0] funct3);
        logic writes;
        writes = (opcode == LUI_OP) || (opcode == AUIPC_OP) ||
                 (opcode == I_TYPE_OP) || (opcode == R_TYPE_OP) ||
                 (opcode == LOAD_OP) || (opcode == JAL_OP) ||
                 (opcode == JALR_OP) || is_csr_op(opcode, funct3);
        return !(writes && (rd != 5'd0));
    endfunction

    assign pop      = head_valid && (ex_cnt != '0);
    assign imm_type = imm_type_from(head_pkt.ir.r.opcode, head_pkt.ir.r.funct3);

    always_comb begin
        dec_d          = '0;
        dec_d.pc       = head_pkt.pc;
        dec_d.rd       = head_pkt.ir.r.rd;
        dec_d.rs1      = head_pkt.ir.r.rs1;
        dec_d.rs2      = head_pkt.ir.r.rs2;
        dec_d.opcode   = head_pkt.ir.r.opcode;
        dec_d.funct3   = head_pkt.ir.r.funct3;
        dec_d.funct7   = head_pkt.ir.r.funct7;
        dec_d.csr_addr = head_pkt.ir.i.imm_11_0;
        dec_d.imm      = imm;
        dec_d.wr_reg_n = wr_reg_n_ctrl(head_pkt.ir.r.opcode, head_pkt.ir.r.rd,
                                       head_pkt.ir.r.funct3);
        dec_d.wr_csr_n = !is_csr_op(head_pkt.ir.r.opcode, head_pkt.ir.r.funct3);
    end

    // Pop and credit return may land on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_cnt    <= EX_CREDIT_W'(EX_CREDITS);
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= pop;
            unique case ({pop, ex_credit})
                2'b10:   ex_cnt <= ex_cnt - 1'b1;
                2'b01:   ex_cnt <= ex_cnt + 1'b1;
                default: ex_cnt <= ex_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec_q <= dec_d;
        end
    end

    // Operand data was read on the same pop edge
    always_comb begin
        dec_pkt          = dec_q;
        dec_pkt.rs1_data = rs1_data;
        dec_pkt.rs2_data = rs2_data;
    end

endmodule

// File: rtl/decode_unit.sv
module decode_unit import rv_decode_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  fetch_pkt_t in_pkt,
    output logic       fetch_credit,
    input  wb_t        wb,
    output logic       dec_valid,
    output decoded_t   dec_pkt,
    input  logic       ex_credit
);

    logic        pop;
    logic        head_valid;
    fetch_pkt_t  head_pkt;
    imm_type_e   imm_type;
    logic [31:0] imm;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    inst_queue u_inst_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_pkt       (in_pkt),
        .pop          (pop),
        .head_valid   (head_valid),
        .head_pkt     (head_pkt),
        .fetch_credit (fetch_credit)
    );

    imm_extractor u_imm_extractor (
        .ir       (head_pkt.ir),
        .imm_type (imm_type),
        .imm      (imm)
    );

    // Source addresses straight from the queue head
    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (head_pkt.ir.r.rs1),
        .rs2      (head_pkt.ir.r.rs2),
        .rd_en    (pop),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    id_stage u_id_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_pkt   (head_pkt),
        .pop        (pop),
        .ex_credit  (ex_credit),
        .imm_type   (imm_type),
        .imm        (imm),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .dec_valid  (dec_valid),
        .dec_pkt    (dec_pkt)
    );

endmodule

// File: dv/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Architectural register state as the execute stage would see it
logic [31:0] shadow_regs [32];

function automatic void clear_shadow();
    for (int i = 0; i < 32; i++) begin
        shadow_regs[i] = '0;
    end
endfunction

// Writes to x0 are lost
function automatic void write_shadow(input wb_t w);
    if (w.we && (w.rd != 5'd0)) begin
        shadow_regs[w.rd] = w.data;
    end
endfunction

function automatic logic [31:0] read_shadow(input logic [4:0] addr);
    if (addr == 5'd0) begin
        return '0;
    end
    return shadow_regs[addr];
endfunction

// Immediate straight from the raw instruction bits
function automatic logic [31:0] imm_of(input logic [31:0] w);
    case (w[6:0])
        LUI_OP, AUIPC_OP:  return {w[31:12], 12'b0};
        JAL_OP:            return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        JALR_OP, LOAD_OP:  return {{20{w[31]}}, w[31:20]};
        BRANCH_OP:         return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        STORE_OP:          return {{20{w[31]}}, w[31:25], w[11:7]};
        I_TYPE_OP: begin
            // SLLI, SRLI, SRAI
            if ((w[14:12] == 3'b001) || (w[14:12] == 3'b101)) begin
                return {27'b0, w[24:20]};
            end
            return {{20{w[31]}}, w[31:20]};
        end
        SYSTEM_OP:         return {27'b0, w[19:15]};
        default:           return '0;
    endcase
endfunction

// Active low, as on the decoded packet
function automatic logic reg_write_n_of(input logic [31:0] w);
    logic writer;
    case (w[6:0])
        LUI_OP, AUIPC_OP, I_TYPE_OP, R_TYPE_OP, LOAD_OP, JAL_OP, JALR_OP: writer = 1'b1;
        SYSTEM_OP: writer = (w[14:12] != 3'b000);
        default:   writer = 1'b0;
    endcase
    return (writer && (w[11:7] != 5'd0)) ? 1'b0 : 1'b1;
endfunction

// ecall and ebreak have funct3 = 0 and touch no CSR
function automatic logic csr_write_n_of(input logic [31:0] w);
    return ((w[6:0] == SYSTEM_OP) && (w[14:12] != 3'b000)) ? 1'b0 : 1'b1;
endfunction

`endif

// File: dv/decode_tb.sv
module decode_tb import rv_decode_pkg::*; ();

    localparam int N_INSTR        = 200;
    localparam int HOLD_AT        = 60;
    localparam int HOLD_CYCLES    = 40;
    localparam int TIMEOUT_CYCLES = N_INSTR * 20 + 200;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       in_valid;
    fetch_pkt_t in_pkt;
    logic       fetch_credit;
    wb_t        wb;
    logic       dec_valid;
    decoded_t   dec_pkt;
    logic       ex_credit;

    fetch_pkt_t exp_q [$];
    int         pkts_sent;
    int         fetch_returned;
    int         rx_count;
    int         credits_sent;
    int         credits_given;
    int         hold_base;
    int         out_of_reset;
    bit         withhold;
    wb_t        pending_wb;

    `include "decode_model.svh"

    task automatic report_failure();
        $display("Finished with errors");
        $fatal(1, "run stopped at the first failed check");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %0h expected %0h", name, got, exp);
            report_failure();
        end
    endtask

    // Small register range most of the time so bypass hits happen
    function automatic logic [4:0] random_reg();
        if ($urandom_range(0, 3) == 0) begin
            return 5'($urandom_range(0, 31));
        end
        return 5'($urandom_range(0, 7));
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        w = $urandom;
        case ($urandom_range(0, 10))
            0:       w[6:0] = LUI_OP;
            1:       w[6:0] = AUIPC_OP;
            2:       w[6:0] = JAL_OP;
            3:       w[6:0] = JALR_OP;
            4:       w[6:0] = BRANCH_OP;
            5:       w[6:0] = LOAD_OP;
            6:       w[6:0] = STORE_OP;
            7:       w[6:0] = I_TYPE_OP;
            8:       w[6:0] = R_TYPE_OP;
            9:       w[6:0] = SYSTEM_OP;
            default: w[6:0] = 7'b0001011;  // custom-0, not an RV32I opcode
        endcase
        w[11:7]  = random_reg();
        w[19:15] = random_reg();
        w[24:20] = random_reg();
        // Corner cases on top of the random mix
        case ($urandom_range(0, 7))
            0: w[11:7] = 5'd0;
            1: begin
                w[6:0]   = SYSTEM_OP;
                w[14:12] = 3'b000;
            end
            2: begin
                w[6:0]   = I_TYPE_OP;
                w[14:12] = ($urandom_range(0, 1) == 1) ? 3'b101 : 3'b001;
            end
            default: ;
        endcase
        return w;
    endfunction

    decode_unit DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_pkt       (in_pkt),
        .fetch_credit (fetch_credit),
        .wb           (wb),
        .dec_valid    (dec_valid),
        .dec_pkt      (dec_pkt),
        .ex_credit    (ex_credit)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // Fetch side
    initial begin
        fetch_pkt_t pkt;
        int         gap;
        bit         counts_ok;
        void'($urandom(32'h335e83a0));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_pkt    = '0;
        wb        = '0;
        ex_credit = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < N_INSTR; n++) begin
            @(posedge clk);
            while (pkts_sent - fetch_returned >= QUEUE_DEPTH) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            pkt.pc = 32'h0000_1000 + 32'(n * 4);
            pkt.ir = random_instr();
            in_valid <= 1'b1;
            in_pkt   <= pkt;
            exp_q.push_back(pkt);
            pkts_sent++;
            if ($urandom_range(0, 3) == 0) begin
                gap = $urandom_range(1, 3);
                repeat (gap) begin
                    @(posedge clk);
                    in_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        wait (rx_count == N_INSTR);
        repeat (4) @(posedge clk);
        counts_ok = (fetch_returned == pkts_sent) && (exp_q.size() == 0);
        assert (counts_ok) else begin
            $display("fetch credits returned %0d for %0d packets accepted, %0d undecoded",
                     fetch_returned, pkts_sent, exp_q.size());
        end
        if (counts_ok) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            report_failure();
        end
    end

    // Execute side credit return, with one long withholding phase
    initial begin
        int unsigned delay;
        int          hold_left;
        bit          held_once;
        delay     = 0;
        hold_left = 0;
        held_once = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            ex_credit <= 1'b0;
            if (!held_once && (rx_count >= HOLD_AT)) begin
                held_once = 1'b1;
                withhold  = 1'b1;
                hold_base = credits_sent;
                hold_left = HOLD_CYCLES;
            end
            if (withhold) begin
                hold_left--;
                if (hold_left == 0) begin
                    withhold = 1'b0;
                    assert (rx_count == hold_base + EX_CREDITS) else begin
                        $display("decode did not stop after spending its execute credits");
                        report_failure();
                    end
                    assert (pkts_sent - fetch_returned == QUEUE_DEPTH) else begin
                        $display("fetch side did not stall behind a full queue");
                        report_failure();
                    end
                end
            end else if (delay != 0) begin
                delay--;
            end else if (credits_sent < rx_count) begin
                ex_credit <= 1'b1;
                credits_sent++;
                delay = $urandom_range(0, 3);
            end
        end
    end

    // Writeback traffic into the register file
    initial begin
        wb_t w;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            w.we   = ($urandom_range(0, 1) == 1);
            w.rd   = random_reg();
            w.data = $urandom;
            wb <= w;
        end
    end

    // Outputs are sampled half a cycle after the edge
    always @(negedge clk) begin
        fetch_pkt_t  exp_pkt;
        logic [31:0] word;
        if (!rst_n || (out_of_reset < 2)) begin
            assert (!dec_valid && !fetch_credit) else begin
                $display("dec_valid or fetch_credit high during or right after reset");
                report_failure();
            end
        end
        if (!rst_n) begin
            out_of_reset = 0;
            pending_wb   = '0;
            clear_shadow();
        end else begin
            out_of_reset++;
            // Write seen on the last edge, bypass makes it visible to that read
            write_shadow(pending_wb);
            if (dec_valid) begin
                assert (exp_q.size() != 0) else begin
                    $display("dec_valid with no packet outstanding");
                    report_failure();
                end
                exp_pkt = exp_q.pop_front();
                word    = exp_pkt.ir;
                rx_count++;
                check_value("dec_pkt.pc", dec_pkt.pc, exp_pkt.pc);
                check_value("dec_pkt.rd", 32'(dec_pkt.rd), 32'(word[11:7]));
                check_value("dec_pkt.rs1", 32'(dec_pkt.rs1), 32'(word[19:15]));
                check_value("dec_pkt.rs2", 32'(dec_pkt.rs2), 32'(word[24:20]));
                check_value("dec_pkt.opcode", 32'(dec_pkt.opcode), 32'(word[6:0]));
                check_value("dec_pkt.funct3", 32'(dec_pkt.funct3), 32'(word[14:12]));
                check_value("dec_pkt.funct7", 32'(dec_pkt.funct7), 32'(word[31:25]));
                check_value("dec_pkt.csr_addr", 32'(dec_pkt.csr_addr), 32'(word[31:20]));
                check_value("dec_pkt.imm", dec_pkt.imm, imm_of(word));
                check_value("dec_pkt.wr_reg_n", 32'(dec_pkt.wr_reg_n),
                            32'(reg_write_n_of(word)));
                check_value("dec_pkt.wr_csr_n", 32'(dec_pkt.wr_csr_n),
                            32'(csr_write_n_of(word)));
                check_value("dec_pkt.rs1_data", dec_pkt.rs1_data, read_shadow(word[19:15]));
                check_value("dec_pkt.rs2_data", dec_pkt.rs2_data, read_shadow(word[24:20]));
            end
            assert (rx_count <= credits_given + EX_CREDITS) else begin
                $display("more packets decoded than execute credits allow");
                report_failure();
            end
            if (withhold) begin
                assert (rx_count <= hold_base + EX_CREDITS) else begin
                    $display("packets kept leaving while execute credits were withheld");
                    report_failure();
                end
            end
            if (ex_credit) begin
                credits_given++;
            end
            if (fetch_credit) begin
                fetch_returned++;
            end
            pending_wb = wb;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * 20);
        $display("watchdog expired with %0d of %0d packets decoded", rx_count, N_INSTR);
        report_failure();
    end

endmodule

// File: build.f
+incdir+dv
rtl/rv_decode_pkg.sv
rtl/imm_extractor.sv
rtl/inst_queue.sv
rtl/reg_file.sv
rtl/id_stage.sv
rtl/decode_unit.sv
dv/decode_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f build.f --top-module decode_tb -o decode_sim; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/decode_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^Finished with no errors$"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
